//--- rtl/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

  // Pixel column, wide enough for 336 columns
  typedef logic [8:0] x_coord_t;

  // Pixel row, wide enough for 210 rows
  typedef logic [7:0] y_coord_t;

  // One bit per channel, ordered R G B
  typedef logic [2:0] color_t;

  // Visible screen size in pixels
  localparam int SCREEN_W = 336;
  localparam int SCREEN_H = 210;

endpackage

`default_nettype wire

//--- rtl/ui_pkg.sv
`default_nettype none

package ui_pkg;

  // Bit positions of the four push-buttons
  localparam int KEY_SETX   = 0;
  localparam int KEY_SETY   = 1;
  localparam int KEY_SETCOL = 2;
  localparam int KEY_GO     = 3;

  // Controller states
  typedef enum logic {
    UI_IDLE,
    UI_BUSY
  } ui_state_t;

  // Line engine states
  typedef enum logic [1:0] {
    LDA_IDLE,
    LDA_INIT,
    LDA_DRAW,
    LDA_DONE
  } lda_state_t;

endpackage

`default_nettype wire

//--- rtl/line_if.sv
`default_nettype none

interface line_if
  import gfx_pkg::*;
();

  // Request from the user interface
  x_coord_t x0;
  y_coord_t y0;
  x_coord_t x1;
  y_coord_t y1;
  color_t   color;
  logic     start;

  // Completion from the line engine
  logic     done;

  modport ui (
    output x0, y0, x1, y1, color, start,
    input  done
  );

  modport lda (
    input  x0, y0, x1, y1, color, start,
    output done
  );

endinterface

`default_nettype wire

//--- rtl/key_sync.sv
`default_nettype none

module key_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic       CLOCK_50,
  input  logic       i_rst,
  input  logic [3:0] i_key,
  output logic [3:0] o_press
);

  // Synchronizer chain, stage 0 samples the raw buttons
  logic [3:0] sync_q [SYNC_STAGES];
  logic [3:0] level;
  logic [3:0] level_prev_q;

  assign level = sync_q[SYNC_STAGES-1];

  always_ff @(posedge CLOCK_50) begin
    if (i_rst) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
      level_prev_q <= '0;
      o_press      <= '0;
    end else begin
      // Inverted so a held button reads as 1
      sync_q[0] <= ~i_key;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      level_prev_q <= level;
      // Rising edge of the pressed level
      o_press      <= level & ~level_prev_q;
    end
  end

  // A held button never yields back-to-back pulses
  assert property (@(posedge CLOCK_50) disable iff (i_rst)
    (o_press & $past(o_press)) == 4'b0000);

endmodule

`default_nettype wire

//--- rtl/user_interface.sv
`default_nettype none

module user_interface
  import gfx_pkg::*, ui_pkg::*;
(
  input  logic       CLOCK_50,
  input  logic       i_rst,
  input  x_coord_t   i_val,
  input  logic [3:0] i_press,
  output logic       o_busy,
  line_if.ui         line
);

  ui_state_t state;

  assign o_busy = (state == UI_BUSY);

  always_ff @(posedge CLOCK_50) begin
    if (i_rst) begin
      state      <= UI_IDLE;
      line.start <= 1'b0;
      line.x0    <= '0;
      line.y0    <= '0;
      line.x1    <= '0;
      line.y1    <= '0;
      line.color <= '0;
    end else begin
      line.start <= 1'b0;
      case (state)
        UI_IDLE: begin
          if (i_press[KEY_SETX]) begin
            line.x1 <= i_val;
          end
          if (i_press[KEY_SETY]) begin
            line.y1 <= y_coord_t'(i_val);
          end
          if (i_press[KEY_SETCOL]) begin
            line.color <= color_t'(i_val);
          end
          // Start pulse and busy rise on the same edge
          if (i_press[KEY_GO]) begin
            line.start <= 1'b1;
            state      <= UI_BUSY;
          end
        end
        UI_BUSY: begin
          // End point becomes the start of the next line
          if (line.done) begin
            line.x0 <= line.x1;
            line.y0 <= line.y1;
            state   <= UI_IDLE;
          end
        end
      endcase
    end
  end

  // One outstanding request at a time across the line handshake
  assert property (@(posedge CLOCK_50) disable iff (i_rst)
    line.start |=> (!line.start until line.done));

endmodule

`default_nettype wire

//--- rtl/line_drawing_algorithm.sv
`default_nettype none

module line_drawing_algorithm
  import gfx_pkg::*, ui_pkg::*;
(
  input  logic     CLOCK_50,
  input  logic     i_rst,
  line_if.lda      line,
  output x_coord_t o_x,
  output y_coord_t o_y,
  output color_t   o_color,
  output logic     o_plot
);

  lda_state_t state;

  // Endpoints on the swapped axes, both held at x width
  logic     steep;
  x_coord_t abs_dx;
  x_coord_t abs_dy;
  x_coord_t pa0, pb0, pa1, pb1;
  x_coord_t ma0, mi0, ma1, mi1;
  x_coord_t dmaj;
  x_coord_t dmin;

  // Walk registers, maj is the axis stepped every cycle
  logic               steep_q;
  logic               min_down_q;
  x_coord_t           maj_q;
  x_coord_t           maj_end_q;
  x_coord_t           min_q;
  x_coord_t           dmaj_q;
  x_coord_t           dmin_q;
  logic signed [10:0] err_q;
  logic signed [10:0] err_next;

  always_comb begin
    abs_dx = (line.x1 > line.x0) ? line.x1 - line.x0 : line.x0 - line.x1;
    abs_dy = (line.y1 > line.y0) ? {1'b0, line.y1} - {1'b0, line.y0}
                                 : {1'b0, line.y0} - {1'b0, line.y1};
    steep  = abs_dy > abs_dx;

    pa0 = steep ? {1'b0, line.y0} : line.x0;
    pb0 = steep ? line.x0 : {1'b0, line.y0};
    pa1 = steep ? {1'b0, line.y1} : line.x1;
    pb1 = steep ? line.x1 : {1'b0, line.y1};

    // Order so the major coordinate increases
    if (pa0 > pa1) begin
      ma0 = pa1;
      mi0 = pb1;
      ma1 = pa0;
      mi1 = pb0;
    end else begin
      ma0 = pa0;
      mi0 = pb0;
      ma1 = pa1;
      mi1 = pb1;
    end

    dmaj = ma1 - ma0;
    dmin = (mi1 > mi0) ? mi1 - mi0 : mi0 - mi1;

    err_next = err_q + $signed({2'b00, dmin_q});
  end

  always_ff @(posedge CLOCK_50) begin
    if (i_rst) begin
      state      <= LDA_IDLE;
      steep_q    <= 1'b0;
      min_down_q <= 1'b0;
      maj_q      <= '0;
      maj_end_q  <= '0;
      min_q      <= '0;
      dmaj_q     <= '0;
      dmin_q     <= '0;
      err_q      <= '0;
    end else begin
      case (state)
        LDA_IDLE: begin
          if (line.start) begin
            state <= LDA_INIT;
          end
        end
        LDA_INIT: begin
          steep_q    <= steep;
          min_down_q <= mi1 < mi0;
          maj_q      <= ma0;
          maj_end_q  <= ma1;
          min_q      <= mi0;
          dmaj_q     <= dmaj;
          dmin_q     <= dmin;
          err_q      <= -$signed({2'b00, dmaj >> 1});
          state      <= LDA_DRAW;
        end
        LDA_DRAW: begin
          if (maj_q == maj_end_q) begin
            state <= LDA_DONE;
          end else begin
            maj_q <= maj_q + 1'b1;
            if (err_next > 11'sd0) begin
              min_q <= min_down_q ? min_q - 1'b1 : min_q + 1'b1;
              err_q <= err_next - $signed({2'b00, dmaj_q});
            end else begin
              err_q <= err_next;
            end
          end
        end
        LDA_DONE: begin
          state <= LDA_IDLE;
        end
      endcase
    end
  end

  // Swap back to screen orientation
  assign o_x       = steep_q ? min_q : maj_q;
  assign o_y       = steep_q ? y_coord_t'(maj_q) : y_coord_t'(min_q);
  assign o_color   = line.color;
  assign o_plot    = (state == LDA_DRAW);
  assign line.done = (state == LDA_DONE);

  // On-screen endpoints keep every pixel on screen
  assert property (@(posedge CLOCK_50) disable iff (i_rst)
    o_plot && line.x0 < SCREEN_W && line.x1 < SCREEN_W
      && line.y0 < SCREEN_H && line.y1 < SCREEN_H
    |-> state == LDA_DRAW && o_x < SCREEN_W && o_y < SCREEN_H);

  // Done only closes a line that plotted on the previous cycle
  assert property (@(posedge CLOCK_50) disable iff (i_rst)
    line.done |-> state == LDA_DONE && $past(o_plot));

endmodule

`default_nettype wire

//--- rtl/line_plot_top.sv
`default_nettype none

module line_plot_top
  import gfx_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic       CLOCK_50,
  input  logic       i_rst,
  input  x_coord_t   i_val,
  input  logic [3:0] i_key,
  output x_coord_t   o_x,
  output y_coord_t   o_y,
  output color_t     o_color,
  output logic       o_plot,
  output logic       o_busy
);

  // One-cycle button pulses
  logic [3:0] press;

  line_if u_line ();

  key_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_key_sync (
    .CLOCK_50    (CLOCK_50),
    .i_rst       (i_rst),
    .i_key       (i_key),
    .o_press     (press)
  );

  user_interface u_user_interface (
    .CLOCK_50    (CLOCK_50),
    .i_rst       (i_rst),
    .i_val       (i_val),
    .i_press     (press),
    .o_busy      (o_busy),
    .line        (u_line.ui)
  );

  // Pixel strobe goes where the VGA adapter plot input would be
  line_drawing_algorithm u_line_drawing_algorithm (
    .CLOCK_50    (CLOCK_50),
    .i_rst       (i_rst),
    .line        (u_line.lda),
    .o_x         (o_x),
    .o_y         (o_y),
    .o_color     (o_color),
    .o_plot      (o_plot)
  );

endmodule

`default_nettype wire

//--- test/tb_line_plot.sv
`default_nettype none

module tb_line_plot
  import gfx_pkg::*, ui_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // About 35 lines of at most 336 pixels, each with some 40 cycles of buttons
  localparam int MAX_CYCLES = 20000;

  logic       CLOCK_50;
  logic       i_rst;
  x_coord_t   i_val;
  logic [3:0] i_key;
  x_coord_t   o_x;
  y_coord_t   o_y;
  color_t     o_color;
  logic       o_plot;
  logic       o_busy;

  // Expected start point, pending end point and color
  x_coord_t    cur_x;
  y_coord_t    cur_y;
  x_coord_t    end_x;
  y_coord_t    end_y;
  color_t      cur_col;
  logic [19:0] got_q[$];
  logic [19:0] exp_q[$];
  int          errors = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          cycles = 0;

  line_plot_top #(
    .SYNC_STAGES (2)
  ) UUT (
    .CLOCK_50 (CLOCK_50),
    .i_rst    (i_rst),
    .i_val    (i_val),
    .i_key    (i_key),
    .o_x      (o_x),
    .o_y      (o_y),
    .o_color  (o_color),
    .o_plot   (o_plot),
    .o_busy   (o_busy)
  );

  initial begin
    CLOCK_50 = 1'b0;
    forever #20 CLOCK_50 = ~CLOCK_50;
  end

  always @(posedge CLOCK_50) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // Pixel outputs settle after the rising edge
  always @(negedge CLOCK_50) begin
    if (o_plot) begin
      got_q.push_back({o_x, o_y, o_color});
    end
  end

  task automatic step(input int n);
    repeat (n) @(posedge CLOCK_50);
    #2;
  endtask

  task automatic fail(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic check_coord(input string what, input x_coord_t gx, input y_coord_t gy,
                             input x_coord_t ex, input y_coord_t ey);
    if (gx !== ex || gy !== ey) begin
      fail($sformatf("%s pixel (%0d,%0d), expected (%0d,%0d)", what, gx, gy, ex, ey));
    end
  endtask

  task automatic check_color(input string what, input color_t got, input color_t exp);
    if (got !== exp) begin
      fail($sformatf("%s color %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      fail($sformatf("%s count %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      fail($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  task automatic press_key(input int idx);
    i_key[idx] = 1'b0;
    step(4);
    i_key[idx] = 1'b1;
    step(4);
  endtask

  task automatic set_point(input x_coord_t x, input y_coord_t y);
    i_val = x;
    press_key(KEY_SETX);
    i_val = x_coord_t'(y);
    press_key(KEY_SETY);
    end_x = x;
    end_y = y;
  endtask

  task automatic set_color(input color_t c);
    i_val = x_coord_t'(c);
    press_key(KEY_SETCOL);
    cur_col = c;
  endtask

  // Bresenham walk on the major axis from the expected endpoints
  task automatic build_expected();
    int  a0, b0, a1, b1, t, a, dx, dy, dmaj, dmin, step_b, err;
    bit  steep;
    dx    = int'(end_x) - int'(cur_x);
    dy    = int'(end_y) - int'(cur_y);
    steep = (dy < 0 ? -dy : dy) > (dx < 0 ? -dx : dx);
    a0    = steep ? int'(cur_y) : int'(cur_x);
    b0    = steep ? int'(cur_x) : int'(cur_y);
    a1    = steep ? int'(end_y) : int'(end_x);
    b1    = steep ? int'(end_x) : int'(end_y);
    if (a0 > a1) begin
      t  = a0;
      a0 = a1;
      a1 = t;
      t  = b0;
      b0 = b1;
      b1 = t;
    end
    dmaj   = a1 - a0;
    dmin   = (b1 > b0) ? b1 - b0 : b0 - b1;
    step_b = (b1 < b0) ? -1 : 1;
    err    = -(dmaj / 2);
    exp_q.delete();
    for (a = a0; a <= a1; a++) begin
      if (steep) begin
        exp_q.push_back({x_coord_t'(b0), y_coord_t'(a), cur_col});
      end else begin
        exp_q.push_back({x_coord_t'(a), y_coord_t'(b0), cur_col});
      end
      err += dmin;
      if (err > 0) begin
        b0  += step_b;
        err -= dmaj;
      end
    end
  endtask

  // Insertion sort, x then y order from the packed layout
  task automatic sort_pixels(ref logic [19:0] q[$]);
    logic [19:0] key;
    int          j;
    for (int i = 1; i < q.size(); i++) begin
      key = q[i];
      j   = i - 1;
      while (j >= 0 && q[j] > key) begin
        q[j+1] = q[j];
        j--;
      end
      q[j+1] = key;
    end
  endtask

  task automatic draw_line(input string name, input bit hold_go, input bit poke);
    int wait_n;
    int e0;
    e0 = errors;
    build_expected();
    got_q.delete();
    i_key[KEY_GO] = 1'b0;
    wait_n = 0;
    while (!o_busy && wait_n < 20) begin
      step(1);
      wait_n++;
    end
    if (!o_busy) begin
      errors++;
      $display("%s: o_busy never went high after go was pressed", name);
    end
    if (!hold_go) begin
      i_key[KEY_GO] = 1'b1;
    end
    // Go and set presses while busy must not touch the request
    if (poke) begin
      // Go stays released long enough for a fresh press
      step(4);
      // Differs from the pending point and color in every field
      i_val = {~end_x[8], ~end_y[7:3], ~cur_col};
      press_key(KEY_GO);
      press_key(KEY_SETX);
      press_key(KEY_SETY);
      press_key(KEY_SETCOL);
    end
    wait_n = 0;
    while (o_busy && wait_n < 400) begin
      step(1);
      wait_n++;
    end
    if (o_busy) begin
      errors++;
      $display("%s: o_busy stayed high, the line never finished", name);
    end
    step(8);
    i_key[KEY_GO] = 1'b1;
    step(8);
    check_flag({name, " o_busy after line"}, o_busy, 1'b0);
    sort_pixels(got_q);
    sort_pixels(exp_q);
    check_count({name, " pixel"}, got_q.size(), exp_q.size());
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      if (errors > e0 + 8) begin
        break;
      end
      check_coord(name, got_q[i][19:11], got_q[i][10:3], exp_q[i][19:11], exp_q[i][10:3]);
      check_color(name, got_q[i][2:0], exp_q[i][2:0]);
    end
    cur_x = end_x;
    cur_y = end_y;
  endtask

  task automatic finish_test(input string name, input int e0);
    if (errors == e0) begin
      tests_ok++;
      $display("ok     %s", name);
    end else begin
      tests_bad++;
      $display("FAILED %s with %0d errors", name, errors - e0);
    end
  endtask

  task automatic test_reset_origin();
    int e0;
    e0 = errors;
    repeat (10) begin
      check_flag("o_plot after reset", o_plot, 1'b0);
      check_flag("o_busy after reset", o_busy, 1'b0);
      step(1);
    end
    draw_line("origin", 1'b0, 1'b0);
    finish_test("reset and single pixel", e0);
  endtask

  task automatic test_axis_lines();
    int e0;
    e0 = errors;
    set_color(3'b101);
    set_point(120, 0);
    draw_line("horizontal", 1'b0, 1'b0);
    set_point(120, 90);
    draw_line("vertical", 1'b0, 1'b0);
    set_point(30, 180);
    draw_line("diagonal", 1'b0, 1'b0);
    finish_test("axis and 45 degree lines", e0);
  endtask

  // Shallow and steep in each of the four quadrants, chained
  task automatic test_directions();
    x_coord_t xs[8] = '{200, 250, 335, 320, 150, 130, 90, 110};
    y_coord_t ys[8] = '{130, 20, 60, 200, 150, 10, 40, 190};
    int       e0;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      set_color(color_t'(i));
      set_point(xs[i], ys[i]);
      draw_line($sformatf("direction %0d", i), 1'b0, 1'b0);
    end
    finish_test("steep and shallow directions", e0);
  endtask

  task automatic test_busy_ignore();
    int e0;
    e0 = errors;
    set_color(3'b011);
    set_point(5, 5);
    draw_line("held go", 1'b1, 1'b0);
    set_color(3'b110);
    set_point(330, 200);
    draw_line("buttons while busy", 1'b0, 1'b1);
    finish_test("go held and presses while busy", e0);
  endtask

  task automatic test_random();
    int e0;
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      set_color(color_t'($urandom % 8));
      set_point(x_coord_t'($urandom % SCREEN_W), y_coord_t'($urandom % SCREEN_H));
      draw_line($sformatf("random %0d", i), 1'b0, 1'b0);
    end
    finish_test("random lines", e0);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'hed0d));
    i_rst   = 1'b1;
    i_val   = '0;
    i_key   = 4'hF;
    cur_x   = '0;
    cur_y   = '0;
    end_x   = '0;
    end_y   = '0;
    cur_col = '0;
    step(10);
    i_rst = 1'b0;
    test_reset_origin();
    test_axis_lines();
    test_directions();
    test_busy_ignore();
    test_random();
    $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
rtl/gfx_pkg.sv
rtl/ui_pkg.sv
rtl/line_if.sv
rtl/key_sync.sv
rtl/user_interface.sv
rtl/line_drawing_algorithm.sv
rtl/line_plot_top.sv
test/tb_line_plot.sv

//--- Bender.yml
package:
  name: line_plot

sources:
  - rtl/gfx_pkg.sv
  - rtl/ui_pkg.sv
  - rtl/line_if.sv
  - rtl/key_sync.sv
  - rtl/user_interface.sv
  - rtl/line_drawing_algorithm.sv
  - rtl/line_plot_top.sv
  - target: test
    files:
      - test/tb_line_plot.sv
